// ==== sources.f ====
+incdir+design
design/tcb_pkg.sv
design/tcb_logsize2byteena.sv
design/tcb_mem_sub.sv
design/tcb_mem_top.sv
verification/tcb_mem_properties.sv
verification/tcb_mem_tb.sv

// ==== Bender.yml ====
package:
  name: tcb_mem

export_include_dirs:
  - design

sources:
  # RTL
  - include_dirs:
      - design
    files:
      - design/tcb_pkg.sv
      - design/tcb_logsize2byteena.sv
      - design/tcb_mem_sub.sv
      - design/tcb_mem_top.sv

  # testbench and bound assertions
  - target: test
    include_dirs:
      - design
    files:
      - verification/tcb_mem_properties.sv
      - verification/tcb_mem_tb.sv

// ==== verification/tcb_mem_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB memory slice testbench
// seeded random log size traffic checked against a byte memory model
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_settings.svh"

module tcb_mem_tb;

  typedef logic [`TCB_ADR_W-1:0] adr_t;

  // traffic window at the top of the address space
  localparam int WIN_BASE    = 'hfc0;
  localparam int WIN_SIZE    = 64;
  localparam int RDY_TIMEOUT = 20;
  localparam int NUM_RANDOM  = 2000;

  logic                  clk;
  logic                  reset;
  logic                  vld;
  tcb_pkg::tcb_log_req_t req;
  logic                  rdy;
  tcb_pkg::tcb_rsp_t     rsp;

  // reference memory with one entry per byte address
  logic [7:0] model [2**`TCB_ADR_W];

  // response due after the next rising edge
  tcb_pkg::tcb_rsp_t exp_rsp;

  int   errors;
  int   checks;
  int   lag;
  logic timed_out;

  tcb_mem_top DUT (
    .clk   (clk),
    .reset (reset),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // expected response of one transfer and model update for writes
  task automatic apply_request(input tcb_pkg::tcb_log_req_t r,
                               output tcb_pkg::tcb_rsp_t p);
    int nbytes;
    nbytes = 0;
    p      = '0;
    case (r.siz)
      tcb_pkg::TCB_BYTE: begin
        nbytes = 1;
      end
      tcb_pkg::TCB_HALF: begin
        if (r.adr[0]) begin
          p.sts = tcb_pkg::TCB_ERR_ALIGN;
        end else begin
          nbytes = 2;
        end
      end
      tcb_pkg::TCB_WORD: begin
        if (r.adr[1:0] != 2'b00) begin
          p.sts = tcb_pkg::TCB_ERR_ALIGN;
        end else begin
          nbytes = 4;
        end
      end
      default: begin
        p.sts = tcb_pkg::TCB_ERR_SIZE;
      end
    endcase
    // little endian payload starts in lane 0
    for (int i = 0; i < nbytes; i++) begin
      if (r.wen) begin
        model[r.adr + i] = r.wdt[8*i +: 8];
      end else begin
        p.rdt[8*i +: 8] = model[r.adr + i];
      end
    end
  endtask

  function automatic tcb_pkg::tcb_log_req_t make_request(input logic wen, input int adr,
                                                         input tcb_pkg::tcb_siz_t siz,
                                                         input logic [31:0] wdt);
    tcb_pkg::tcb_log_req_t r;
    r.wen = wen;
    r.adr = adr_t'(adr);
    r.siz = siz;
    r.wdt = wdt;
    return r;
  endfunction

  // sizes weighted toward legal codes
  function automatic tcb_pkg::tcb_log_req_t random_request();
    tcb_pkg::tcb_log_req_t r;
    int                    pick;
    logic [1:0]            off;
    pick  = $urandom_range(0, 15);
    off   = 2'($urandom_range(0, 3));
    r.wen = 1'($urandom_range(0, 1));
    r.wdt = $urandom();
    if (pick < 5) begin
      r.siz = tcb_pkg::TCB_BYTE;
    end else if (pick < 10) begin
      r.siz = tcb_pkg::TCB_HALF;
    end else if (pick < 14) begin
      r.siz = tcb_pkg::TCB_WORD;
    end else begin
      r.siz = tcb_pkg::TCB_RSVD;
    end
    // mostly aligned with some misaligned left in
    if ((r.siz != tcb_pkg::TCB_BYTE) && ($urandom_range(0, 3) != 0)) begin
      off[0] = 1'b0;
      if (r.siz == tcb_pkg::TCB_WORD) begin
        off[1] = 1'b0;
      end
    end
    r.adr      = adr_t'(WIN_BASE + $urandom_range(0, WIN_SIZE - 1));
    r.adr[1:0] = off;
    return r;
  endfunction

  task automatic check_response();
    checks++;
    if (rsp.rdt !== exp_rsp.rdt) begin
      $display("[ERROR] %0t rsp.rdt expected %h got %h", $time, exp_rsp.rdt, rsp.rdt);
      errors++;
    end
    if (rsp.sts !== exp_rsp.sts) begin
      $display("[ERROR] %0t rsp.sts expected %0d got %0d", $time, exp_rsp.sts, rsp.sts);
      errors++;
    end
  endtask

  // drive one bus cycle and check the previous transfer
  task automatic run_cycle(input logic v, input tcb_pkg::tcb_log_req_t r);
    tcb_pkg::tcb_rsp_t nxt;
    @(posedge clk);
    vld <= v;
    req <= r;
    @(negedge clk);
    check_response();
    if (rdy !== 1'b1) begin
      $display("[ERROR] %0t rdy expected 1 got %b", $time, rdy);
      errors++;
    end
    nxt = '0;
    if (v) begin
      apply_request(r, nxt);
    end
    exp_rsp = nxt;
  endtask

  task automatic wait_ready(output int waited, output logic expired);
    waited  = 0;
    expired = 1'b0;
    @(negedge clk);
    while ((rdy !== 1'b1) && !expired) begin
      waited++;
      if (waited >= RDY_TIMEOUT) begin
        expired = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    tcb_pkg::tcb_log_req_t r;
    int                    base;
    void'($urandom(32'hc43e7f01));
    reset     = 1'b1;
    vld       = 1'b0;
    req       = '0;
    exp_rsp   = '0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    base      = WIN_BASE + 8;

    // rdy stays low through reset
    repeat (9) begin
      @(posedge clk);
      @(negedge clk);
      if (rdy !== 1'b0) begin
        $display("[ERROR] %0t rdy expected 0 got %b", $time, rdy);
        errors++;
      end
    end
    @(posedge clk);
    reset <= 1'b0;

    wait_ready(lag, timed_out);
    if (timed_out) begin
      $display("rdy never rose after reset was released");
      errors++;
    end else begin
      if (lag != 1) begin
        $display("rdy rose %0d cycles after reset release instead of 1", lag);
        errors++;
      end
      // fill the window with a pattern from the full address
      for (int a = WIN_BASE; a < WIN_BASE + WIN_SIZE; a += 4) begin
        run_cycle(1'b1, make_request(1'b1, a, tcb_pkg::TCB_WORD,
                                     {4'h9, adr_t'(a), 4'h6, ~adr_t'(a)}));
      end
      // partial writes merged into one word
      run_cycle(1'b1, make_request(1'b1, base, tcb_pkg::TCB_WORD, 32'h11223344));
      run_cycle(1'b1, make_request(1'b1, base + 1, tcb_pkg::TCB_BYTE, 32'h000000ab));
      run_cycle(1'b1, make_request(1'b1, base + 2, tcb_pkg::TCB_HALF, 32'h0000cdef));
      run_cycle(1'b1, make_request(1'b0, base, tcb_pkg::TCB_WORD, '0));
      // misaligned, reserved size and idle must not touch memory
      run_cycle(1'b1, make_request(1'b1, base + 1, tcb_pkg::TCB_HALF, 32'h00005555));
      run_cycle(1'b1, make_request(1'b1, base + 2, tcb_pkg::TCB_WORD, 32'h66666666));
      run_cycle(1'b1, make_request(1'b1, base, tcb_pkg::TCB_RSVD, 32'h77777777));
      run_cycle(1'b0, make_request(1'b1, base, tcb_pkg::TCB_WORD, 32'h88888888));
      run_cycle(1'b1, make_request(1'b0, base, tcb_pkg::TCB_WORD, '0));
      // every lane back at lane 0
      for (int i = 0; i < 4; i++) begin
        run_cycle(1'b1, make_request(1'b0, base + i, tcb_pkg::TCB_BYTE, '0));
      end
      run_cycle(1'b1, make_request(1'b0, base, tcb_pkg::TCB_HALF, '0));
      run_cycle(1'b1, make_request(1'b0, base + 2, tcb_pkg::TCB_HALF, '0));

      // random mix of transfers and idle cycles
      repeat (NUM_RANDOM) begin
        r = random_request();
        run_cycle(($urandom_range(0, 3) != 0), r);
      end
      // drain the last responses
      repeat (2) begin
        run_cycle(1'b0, '0);
      end
    end

    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, DUT.u_props.fail_cnt);
    if ((errors == 0) && (DUT.u_props.fail_cnt == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/tcb_mem_properties.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB memory slice assertions
// reset handshake, idle response and error gating at the top level
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tcb_mem_properties (
  input logic                  clk,
  input logic                  reset,
  input logic                  vld,
  input logic                  rdy,
  input tcb_pkg::tcb_log_req_t req,
  input tcb_pkg::tcb_rsp_t     rsp,
  input logic                  man_vld
);

  // request breaks the size or alignment rules
  logic req_bad;

  // number of assertion failures so far
  int fail_cnt = 0;

  assign req_bad = (req.siz == tcb_pkg::TCB_RSVD) ||
                   ((req.siz == tcb_pkg::TCB_HALF) && req.adr[0]) ||
                   ((req.siz == tcb_pkg::TCB_WORD) && (req.adr[1:0] != 2'b00));

  // rdy low once reset has been seen for a cycle
  rdy_low_in_reset: assert property (
    @(posedge clk) (reset ##1 reset) |-> !rdy
  ) else begin
    $error("rdy high during reset");
    fail_cnt++;
  end

  // cycle without transfer gives zero data and okay status next
  idle_rsp_zero: assert property (
    @(posedge clk) disable iff (reset)
    !(vld && rdy) |=> (rsp == '0)
  ) else begin
    $error("nonzero response after an idle cycle");
    fail_cnt++;
  end

  // bad requests stay away from the memory
  no_bad_man_vld: assert property (
    @(posedge clk) disable iff (reset)
    man_vld |-> (vld && !req_bad)
  ) else begin
    $error("man_vld high for an erroneous request");
    fail_cnt++;
  end

endmodule

bind tcb_mem_top tcb_mem_properties u_props (
  .clk     (clk),
  .reset   (reset),
  .vld     (vld),
  .rdy     (rdy),
  .req     (req),
  .rsp     (rsp),
  .man_vld (man_vld)
);

`default_nettype wire

// ==== design/tcb_mem_top.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB memory slice top
// log size conversion stage followed by byte enabled memory
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_settings.svh"

module tcb_mem_top (
  input  logic                  clk,
  input  logic                  reset,
  // manager side, log size mode
  input  logic                  vld,
  input  tcb_pkg::tcb_log_req_t req,
  output logic                  rdy,
  output tcb_pkg::tcb_rsp_t     rsp
);

  // byte enable bus between the stages
  logic                  man_vld;
  tcb_pkg::tcb_ben_req_t man_req;
  logic                  man_rdy;
  tcb_pkg::tcb_rsp_t     man_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // conversion stage
  ////////////////////////////////////////////////////////////////////////////

  tcb_logsize2byteena u_conv (
    .clk     (clk),
    .reset   (reset),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp     (rsp),
    .man_vld (man_vld),
    .man_req (man_req),
    .man_rdy (man_rdy),
    .man_rsp (man_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // memory
  ////////////////////////////////////////////////////////////////////////////

  tcb_mem_sub u_mem (
    .clk   (clk),
    .reset (reset),
    .vld   (man_vld),
    .req   (man_req),
    .rdy   (man_rdy),
    .rsp   (man_rsp)
  );

endmodule

`default_nettype wire

// ==== design/tcb_mem_sub.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB byte enabled memory subordinate
// one transfer per cycle, read data registered one cycle later
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_settings.svh"

module tcb_mem_sub (
  input  logic                  clk,
  input  logic                  reset,
  // byte enable mode request
  input  logic                  vld,
  input  tcb_pkg::tcb_ben_req_t req,
  output logic                  rdy,
  output tcb_pkg::tcb_rsp_t     rsp
);

  // word organized storage
  logic [`TCB_BUS_BEN-1:0][7:0] mem [2**`TCB_MEM_AW];

  // word index above the lane bits
  logic [`TCB_MEM_AW-1:0] idx;

  // handshake
  logic trn;

  // lane views
  logic [`TCB_BUS_BEN-1:0][7:0] wdt_lan;
  logic [`TCB_BUS_BEN-1:0][7:0] rdt_d;
  logic [`TCB_BUS_DW-1:0]       rdt_q;

  assign idx     = req.adr[`TCB_MEM_AW+1:2];
  assign wdt_lan = req.wdt;
  assign trn     = vld && rdy;

  ////////////////////////////////////////////////////////////////////////////
  // ready
  ////////////////////////////////////////////////////////////////////////////

  // low in reset, then always ready
  always_ff @(posedge clk) begin
    if (reset) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (trn && req.wen) begin
      for (int i = 0; i < `TCB_BUS_BEN; i++) begin
        // only enabled lanes
        if (req.ben[i]) begin
          mem[idx][i] <= wdt_lan[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read
  ////////////////////////////////////////////////////////////////////////////

  // masked read lanes, zero when no read
  always_comb begin
    rdt_d = '0;
    if (trn && !req.wen) begin
      for (int i = 0; i < `TCB_BUS_BEN; i++) begin
        rdt_d[i] = req.ben[i] ? mem[idx][i] : 8'h00;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rdt_q <= '0;
    end else begin
      rdt_q <= rdt_d;
    end
  end

  assign rsp.rdt = rdt_q;
  // memory itself never fails
  assign rsp.sts = tcb_pkg::TCB_OKAY;

endmodule

`default_nettype wire

// ==== design/tcb_logsize2byteena.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB log size to byte enable conversion
// aligned little endian only, flags misaligned and reserved size requests
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_settings.svh"

module tcb_logsize2byteena (
  input  logic                  clk,
  input  logic                  reset,
  // subordinate side, log size mode
  input  logic                  vld,
  input  tcb_pkg::tcb_log_req_t req,
  output logic                  rdy,
  output tcb_pkg::tcb_rsp_t     rsp,
  // manager side, byte enable mode
  output logic                  man_vld,
  output tcb_pkg::tcb_ben_req_t man_req,
  input  logic                  man_rdy,
  input  tcb_pkg::tcb_rsp_t     man_rsp
);

  // per transfer info kept until the response
  typedef struct packed {
    logic              trn;
    logic              wen;
    tcb_pkg::tcb_siz_t siz;
    logic [1:0]        off;
    tcb_pkg::tcb_sts_t sts;
  } dly_t;

  // address offset within the word
  logic [1:0] req_off;

  // request classification
  tcb_pkg::tcb_sts_t req_sts;

  // lane views of the data
  logic [`TCB_BUS_BEN-1:0][7:0] req_lan;
  logic [`TCB_BUS_BEN-1:0][7:0] man_lan;
  logic [`TCB_BUS_BEN-1:0][7:0] rsp_lan;

  // delay line
  dly_t dly_d;
  dly_t dly_q [`TCB_HSK_DLY];
  dly_t dly_out;

  ////////////////////////////////////////////////////////////////////////////
  // request
  ////////////////////////////////////////////////////////////////////////////

  assign req_off = req.adr[1:0];
  assign req_lan = req.wdt;

  // byte enable and error check
  always_comb begin
    man_req.ben = '0;
    req_sts     = tcb_pkg::TCB_OKAY;
    case (req.siz)
      tcb_pkg::TCB_BYTE: begin
        // single lane at the offset
        man_req.ben = 4'b0001 << req_off;
      end
      tcb_pkg::TCB_HALF: begin
        if (req_off[0]) begin
          req_sts = tcb_pkg::TCB_ERR_ALIGN;
        end else begin
          man_req.ben = req_off[1] ? 4'b1100 : 4'b0011;
        end
      end
      tcb_pkg::TCB_WORD: begin
        if (req_off != 2'b00) begin
          req_sts = tcb_pkg::TCB_ERR_ALIGN;
        end else begin
          man_req.ben = 4'b1111;
        end
      end
      default: begin
        req_sts = tcb_pkg::TCB_ERR_SIZE;
      end
    endcase
  end

  // replicate payload over all lanes
  always_comb begin
    case (req.siz)
      tcb_pkg::TCB_BYTE: man_req.wdt = {4{req_lan[0]}};
      tcb_pkg::TCB_HALF: man_req.wdt = {2{req_lan[1:0]}};
      tcb_pkg::TCB_WORD: man_req.wdt = req_lan;
      default:           man_req.wdt = '0;
    endcase
  end

  assign man_req.wen = req.wen;
  assign man_req.adr = req.adr;

  // bad requests never reach the memory
  assign man_vld = vld && (req_sts == tcb_pkg::TCB_OKAY);

  // memory never stalls, pass its ready back
  assign rdy = man_rdy;

  ////////////////////////////////////////////////////////////////////////////
  // delay line
  ////////////////////////////////////////////////////////////////////////////

  // entry for the current cycle, idle cycles keep okay status
  always_comb begin
    dly_d.trn = vld && rdy;
    dly_d.wen = req.wen;
    dly_d.siz = req.siz;
    dly_d.off = req_off;
    dly_d.sts = dly_d.trn ? req_sts : tcb_pkg::TCB_OKAY;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `TCB_HSK_DLY; i++) begin
        dly_q[i] <= '0;
      end
    end else begin
      dly_q[0] <= dly_d;
      // deeper delays shift along
      for (int i = 1; i < `TCB_HSK_DLY; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  assign dly_out = dly_q[`TCB_HSK_DLY-1];

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  assign man_lan = man_rsp.rdt;

  // move addressed lanes down to lane 0
  always_comb begin
    rsp_lan = '0;
    if (dly_out.trn && !dly_out.wen && (dly_out.sts == tcb_pkg::TCB_OKAY)) begin
      case (dly_out.siz)
        tcb_pkg::TCB_BYTE: rsp_lan[0]   = man_lan[dly_out.off];
        tcb_pkg::TCB_HALF: rsp_lan[1:0] = dly_out.off[1] ? man_lan[3:2] : man_lan[1:0];
        tcb_pkg::TCB_WORD: rsp_lan      = man_lan;
        default:           rsp_lan      = '0;
      endcase
    end
  end

  assign rsp.rdt = rsp_lan;

  // local error wins over memory status
  assign rsp.sts = (dly_out.sts != tcb_pkg::TCB_OKAY) ? dly_out.sts : man_rsp.sts;

endmodule

`default_nettype wire

// ==== design/tcb_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB types for log size and byte enable bus modes
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_settings.svh"

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////////

  // transfer size, log2 of the byte count
  typedef enum logic [1:0] {
    TCB_BYTE = 2'd0,
    TCB_HALF = 2'd1,
    TCB_WORD = 2'd2,
    // illegal on this bus
    TCB_RSVD = 2'd3
  } tcb_siz_t;

  // response status
  typedef enum logic [1:0] {
    TCB_OKAY      = 2'd0,
    TCB_ERR_ALIGN = 2'd1,
    TCB_ERR_SIZE  = 2'd2
  } tcb_sts_t;

  //////////////////////////////////////////////////////////////////////////
  // bus payloads
  //////////////////////////////////////////////////////////////////////////

  // log size request, payload in low lanes
  typedef struct packed {
    logic                   wen;
    logic [`TCB_ADR_W-1:0]  adr;
    tcb_siz_t               siz;
    logic [`TCB_BUS_DW-1:0] wdt;
  } tcb_log_req_t;

  // byte enable request, payload on addressed lanes
  typedef struct packed {
    logic                    wen;
    logic [`TCB_ADR_W-1:0]   adr;
    logic [`TCB_BUS_BEN-1:0] ben;
    logic [`TCB_BUS_DW-1:0]  wdt;
  } tcb_ben_req_t;

  // response, shared by both modes
  typedef struct packed {
    logic [`TCB_BUS_DW-1:0] rdt;
    tcb_sts_t               sts;
  } tcb_rsp_t;

endpackage

`default_nettype wire

// ==== design/tcb_settings.svh ====
////////////////////////////////////////////////////////////////////////////
// TCB memory slice settings
// bus geometry, memory depth and response timing
////////////////////////////////////////////////////////////////////////////

`ifndef TCB_SETTINGS_SVH
`define TCB_SETTINGS_SVH

// data bus width in bits
`define TCB_BUS_DW 32

// byte lanes on the data bus
`define TCB_BUS_BEN 4

// byte address width of the request
`define TCB_ADR_W 12

// memory word address width, 1024 words
`define TCB_MEM_AW 10

// response delay in cycles after the transfer
`define TCB_HSK_DLY 1

`endif
